// File: hdl/cache_pkg.sv
// cache geometry and shared types
// two-way set-associative write-back data cache, 4 sets of 4 words
package cache_pkg;

    // sizes
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int SETS           = 4;
    localparam int WAYS           = 2;

    // processor word address split into tag / index / offset
    localparam int ADDR_W     = 30;
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 2;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int MEM_ADDR_W = TAG_W + INDEX_W;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // one bit is enough to name a way in a two-way cache
    typedef logic way_t;

    // miss handling states
    typedef enum logic [1:0] {
        S_IDLE       = 2'd0,
        S_WRITE_BACK = 2'd1,
        S_ALLOCATE   = 2'd2,
        S_RESPOND    = 2'd3
    } ctrl_state_t;

endpackage

// File: hdl/line_ram.sv
// one way of tag or line storage, one entry per set
// combinational read, write lands on the next edge
`timescale 1ns/1ps

module line_ram
    import cache_pkg::*;
#(
    parameter type entry_t = line_t
) (
    input  logic   clk,
    input  index_t index,
    input  logic   wr_en,
    input  entry_t wr_entry,
    output entry_t rd_entry
);

    // contents are meaningless until the valid bit for the set is up
    entry_t mem [SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= wr_entry;
        end
    end

    assign rd_entry = mem[index];

endmodule

// File: hdl/set_status.sv
// per-set valid, dirty and LRU state
// picks the replacement way, empty ways first
`timescale 1ns/1ps

module set_status
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            proc_reset,
    input  index_t          index,
    input  logic            touch,
    input  way_t            touch_way,
    input  logic            fill,
    input  way_t            fill_way,
    input  logic            mark_dirty,
    input  way_t            dirty_way,
    output logic [WAYS-1:0] valid,
    output way_t            victim_way,
    output logic            victim_dirty
);

    logic [WAYS-1:0] valid_q [SETS];
    logic [WAYS-1:0] dirty_q [SETS];
    // points at the least recently used way of the set
    way_t            lru_q   [SETS];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            if (touch) begin
                lru_q[index] <= ~touch_way;
            end
            if (fill) begin
                valid_q[index][fill_way] <= 1'b1;
                dirty_q[index][fill_way] <= 1'b0;
                lru_q[index]             <= ~fill_way;
            end
            // after the fill so a write-allocate ends up dirty
            if (mark_dirty) begin
                dirty_q[index][dirty_way] <= 1'b1;
            end
        end
    end

    assign valid = valid_q[index];

    always_comb begin
        if (!valid[0]) begin
            victim_way = 1'b0;
        end else if (!valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    // an empty way is never dirty, fill always clears it
    assign victim_dirty = dirty_q[index][victim_way];

endmodule

// File: hdl/way_lookup.sv
// tag compare and word select for both ways
// also builds the line written back into the data array
`timescale 1ns/1ps

module way_lookup
    import cache_pkg::*;
(
    input  tag_t            req_tag,
    input  offset_t         offset,
    input  word_t           wdata,
    input  logic [WAYS-1:0] valid,
    input  tag_t            tag0,
    input  tag_t            tag1,
    input  line_t           line0,
    input  line_t           line1,
    input  way_t            victim_way,
    input  logic            fill,
    input  line_t           fill_line,
    input  logic            merge_word,
    output logic            hit,
    output way_t            hit_way,
    output word_t           rdata,
    output tag_t            victim_tag,
    output line_t           victim_line,
    output line_t           wr_line
);

    logic  hit0;
    logic  hit1;
    line_t hit_line;

    assign hit0 = valid[0] && (tag0 == req_tag);
    assign hit1 = valid[1] && (tag1 == req_tag);
    assign hit  = hit0 || hit1;

    // way 0 wins, both hitting cannot happen since a fill only runs on a miss
    assign hit_way  = hit0 ? 1'b0 : 1'b1;
    assign hit_line = hit0 ? line0 : line1;

    // word k sits at bits 32k upward
    assign rdata = hit ? hit_line[offset*WORD_W +: WORD_W] : '0;

    assign victim_tag  = victim_way ? tag1 : tag0;
    assign victim_line = victim_way ? line1 : line0;

    always_comb begin
        wr_line = fill ? fill_line : hit_line;
        if (merge_word) begin
            wr_line[offset*WORD_W +: WORD_W] = wdata;
        end
    end

endmodule

// File: hdl/cache_ctrl.sv
// miss FSM, drives stall, memory requests and array strobes
// hits finish in idle, misses go through write-back and allocate
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            proc_reset,
    input  logic            proc_read,
    input  logic            proc_write,
    input  tag_t            req_tag,
    input  index_t          index,
    input  logic            hit,
    input  way_t            hit_way,
    input  way_t            victim_way,
    input  logic            victim_dirty,
    input  tag_t            victim_tag,
    input  logic            mem_ready,
    output logic            proc_stall,
    output logic            mem_read,
    output logic            mem_write,
    output mem_addr_t       mem_addr,
    output logic [WAYS-1:0] tag_we,
    output logic [WAYS-1:0] data_we,
    output logic            fill,
    output logic            merge_word,
    output logic            touch,
    output logic            mark_dirty,
    output way_t            upd_way
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        req;
    logic        alloc;

    assign req = proc_read || proc_write;

    // on a miss hit is low, so this falls to the victim
    assign upd_way = hit ? hit_way : victim_way;

    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = {req_tag, index};
        tag_we     = '0;
        data_we    = '0;
        fill       = 1'b0;
        merge_word = 1'b0;
        touch      = 1'b0;
        mark_dirty = 1'b0;
        alloc      = 1'b0;

        case (state_q)
            S_IDLE, S_RESPOND: begin
                if (state_q == S_RESPOND) begin
                    state_d = S_IDLE;
                end
                if (req && hit) begin
                    touch = 1'b1;
                    if (proc_write) begin
                        data_we[hit_way] = 1'b1;
                        merge_word       = 1'b1;
                        mark_dirty       = 1'b1;
                    end
                end else if (req && victim_dirty) begin
                    // victim has to go out before the refill
                    proc_stall = 1'b1;
                    state_d    = S_WRITE_BACK;
                end else if (req) begin
                    alloc = 1'b1;
                end
            end
            S_WRITE_BACK: begin
                proc_stall = 1'b1;
                mem_write  = 1'b1;
                mem_addr   = {victim_tag, index};
                if (mem_ready) begin
                    state_d = S_ALLOCATE;
                end
            end
            default: begin
                alloc = 1'b1;
            end
        endcase

        // refill request, shared by a clean miss in idle and the allocate state
        if (alloc) begin
            proc_stall = 1'b1;
            mem_read   = 1'b1;
            state_d    = S_ALLOCATE;
            if (mem_ready) begin
                fill                = 1'b1;
                tag_we[victim_way]  = 1'b1;
                data_we[victim_way] = 1'b1;
                if (proc_write) begin
                    // write completes now, word merged into the fetched line
                    merge_word = 1'b1;
                    mark_dirty = 1'b1;
                    proc_stall = 1'b0;
                    state_d    = S_IDLE;
                end else begin
                    state_d = S_RESPOND;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: hdl/cache_top.sv
// two-way write-back data cache top level
// wires the tag/data arrays, status bits, lookup and miss FSM together
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              proc_reset,
    input  logic              proc_read,
    input  logic              proc_write,
    input  logic [ADDR_W-1:0] proc_addr,
    input  word_t             proc_wdata,
    output logic              proc_stall,
    output word_t             proc_rdata,
    output logic              mem_read,
    output logic              mem_write,
    output mem_addr_t         mem_addr,
    input  line_t             mem_rdata,
    output line_t             mem_wdata,
    input  logic              mem_ready
);

    tag_t            req_tag;
    index_t          index;
    offset_t         offset;
    tag_t            tag_rd  [WAYS];
    line_t           line_rd [WAYS];
    logic [WAYS-1:0] valid;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;
    way_t            victim_way;
    logic            victim_dirty;
    tag_t            victim_tag;
    line_t           wr_line;
    logic            hit;
    way_t            hit_way;
    logic            fill;
    logic            merge_word;
    logic            touch;
    logic            mark_dirty;
    way_t            upd_way;

    assign req_tag = proc_addr[ADDR_W-1 -: TAG_W];
    assign index   = proc_addr[OFFSET_W +: INDEX_W];
    assign offset  = proc_addr[OFFSET_W-1:0];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        line_ram #(.entry_t(tag_t)) i_tag_ram (
            .clk      (clk),
            .index    (index),
            .wr_en    (tag_we[w]),
            .wr_entry (req_tag),
            .rd_entry (tag_rd[w])
        );

        line_ram #(.entry_t(line_t)) i_data_ram (
            .clk      (clk),
            .index    (index),
            .wr_en    (data_we[w]),
            .wr_entry (wr_line),
            .rd_entry (line_rd[w])
        );
    end

    set_status i_status (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .touch        (touch),
        .touch_way    (upd_way),
        .fill         (fill),
        .fill_way     (upd_way),
        .mark_dirty   (mark_dirty),
        .dirty_way    (upd_way),
        .valid        (valid),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    // write-back data is always the victim line
    way_lookup i_lookup (
        .req_tag     (req_tag),
        .offset      (offset),
        .wdata       (proc_wdata),
        .valid       (valid),
        .tag0        (tag_rd[0]),
        .tag1        (tag_rd[1]),
        .line0       (line_rd[0]),
        .line1       (line_rd[1]),
        .victim_way  (victim_way),
        .fill        (fill),
        .fill_line   (mem_rdata),
        .merge_word  (merge_word),
        .hit         (hit),
        .hit_way     (hit_way),
        .rdata       (proc_rdata),
        .victim_tag  (victim_tag),
        .victim_line (mem_wdata),
        .wr_line     (wr_line)
    );

    cache_ctrl i_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .req_tag      (req_tag),
        .index        (index),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .fill         (fill),
        .merge_word   (merge_word),
        .touch        (touch),
        .mark_dirty   (mark_dirty),
        .upd_way      (upd_way)
    );

endmodule

// File: test/cache_assertions.sv
// protocol checks on the cache memory port and processor stall
`timescale 1ns/1ps

module cache_assertions
    import cache_pkg::*;
(
    input logic      clk,
    input logic      proc_reset,
    input logic      proc_stall,
    input logic      mem_read,
    input logic      mem_write,
    input mem_addr_t mem_addr,
    input line_t     mem_wdata,
    input logic      mem_ready
);

    // number of failed assertions
    int fail_count = 0;

    a_one_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write high together");
        end

    // a write miss may finish in the ready cycle, so stall is only required before it
    a_stall_on_request: assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && !mem_ready) |-> proc_stall)
        else begin
            fail_count++;
            $error("memory request pending without proc_stall");
        end

    a_write_held: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr) && $stable(mem_wdata)))
        else begin
            fail_count++;
            $error("write-back request changed before mem_ready");
        end

    a_read_held: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
        else begin
            fail_count++;
            $error("refill request changed before mem_ready");
        end

endmodule

// File: test/cache_tb.sv
// directed testbench for the two-way write-back data cache
// checks hits, misses and evictions against a random-filled memory model
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
;

    localparam int HALF_PERIOD     = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
    localparam int STALL_LIMIT     = 50;
    localparam int MODEL_LINES     = 64;

    logic              clk = 1'b0;
    logic              proc_reset;
    logic              proc_read;
    logic              proc_write;
    logic [ADDR_W-1:0] proc_addr;
    word_t             proc_wdata;
    logic              proc_stall;
    word_t             proc_rdata;
    logic              mem_read;
    logic              mem_write;
    mem_addr_t         mem_addr;
    line_t             mem_rdata;
    line_t             mem_wdata;
    logic              mem_ready;

    integer    seed;
    int        errors;
    int        checks;
    line_t     mem_model [MODEL_LINES];
    mem_addr_t wb_addr [$];
    line_t     wb_line [$];
    mem_addr_t last_rd_addr;
    int        wait_cnt;
    int        latency;
    logic      req_q;
    logic      wr_q;
    mem_addr_t addr_q;
    line_t     wdata_q;

    always #HALF_PERIOD clk = ~clk;

    cache_top i_dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    bind cache_top cache_assertions i_assertions (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    // requests seen at the clock edge are answered at the falling edge
    always @(posedge clk) begin
        req_q   <= mem_read || mem_write;
        wr_q    <= mem_write;
        addr_q  <= mem_addr;
        wdata_q <= mem_wdata;
    end

    always @(negedge clk) begin
        if (proc_reset || mem_ready) begin
            mem_ready = 1'b0;
            wait_cnt  = 0;
        end else if (req_q) begin
            if (wait_cnt == 0) begin
                latency = 1 + int'($unsigned($random(seed)) % 4);
            end
            wait_cnt++;
            if (wait_cnt >= latency) begin
                if (addr_q[MEM_ADDR_W-1:6] != '0) begin
                    errors++;
                    $display("memory access at %0t ns outside the modeled lines", $time);
                end
                mem_ready = 1'b1;
                if (wr_q) begin
                    mem_model[addr_q[5:0]] = wdata_q;
                    wb_addr.push_back(addr_q);
                    wb_line.push_back(wdata_q);
                end else begin
                    mem_rdata    = mem_model[addr_q[5:0]];
                    last_rd_addr = addr_q;
                end
            end
        end
    end

    function automatic mem_addr_t line_addr(input int tag, input int idx);
        return {tag_t'(tag), index_t'(idx)};
    endfunction

    function automatic line_t model_line(input int tag, input int idx);
        mem_addr_t a;
        a = line_addr(tag, idx);
        return mem_model[a[5:0]];
    endfunction

    // word k of a line sits at bits 32k upward
    function automatic word_t word_of(input line_t line, input int off);
        return line[off*WORD_W +: WORD_W];
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mem_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // drives one processor request and holds it until stall is low
    task automatic access(input logic wr, input int tag, input int idx, input int off,
                          input word_t wdata, output word_t rdata, output logic used_mem,
                          output logic stalled);
        int cycles;
        proc_addr  = {tag_t'(tag), index_t'(idx), offset_t'(off)};
        proc_wdata = wdata;
        proc_read  = !wr;
        proc_write = wr;
        used_mem   = 1'b0;
        stalled    = 1'b0;
        cycles     = 0;
        do begin
            @(posedge clk);
            used_mem = used_mem | mem_read | mem_write;
            stalled  = stalled | proc_stall;
            cycles++;
        end while (proc_stall && cycles < STALL_LIMIT);
        if (proc_stall) begin
            errors++;
            $display("stall stuck high for %0d cycles at %0t ns", cycles, $time);
        end
        rdata = proc_rdata;
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic test_reset_and_first_read();
        word_t rd;
        logic  used;
        logic  stalled;
        @(posedge clk);
        check_flag("proc_stall", 1'b0, proc_stall);
        check_flag("mem_read", 1'b0, mem_read);
        check_flag("mem_write", 1'b0, mem_write);
        @(negedge clk);
        access(1'b0, 1, 0, 2, '0, rd, used, stalled);
        check_flag("memory request", 1'b1, used);
        check_word("proc_rdata", word_of(model_line(1, 0), 2), rd);
    endtask

    task automatic test_read_hit();
        word_t rd;
        logic  used;
        logic  stalled;
        access(1'b0, 1, 0, 3, '0, rd, used, stalled);
        check_flag("proc_stall", 1'b0, stalled);
        check_flag("memory request", 1'b0, used);
        check_word("proc_rdata", word_of(model_line(1, 0), 3), rd);
    endtask

    task automatic test_write_paths();
        word_t rd;
        logic  used;
        logic  stalled;
        line_t ref_line;
        access(1'b1, 1, 0, 1, 32'hcafe_0001, rd, used, stalled);
        check_flag("memory request", 1'b0, used);
        access(1'b0, 1, 0, 1, '0, rd, used, stalled);
        check_word("proc_rdata", 32'hcafe_0001, rd);
        // write miss allocates the line and merges the word
        ref_line = model_line(2, 1);
        access(1'b1, 2, 1, 0, 32'hbeef_0200, rd, used, stalled);
        check_flag("memory request", 1'b1, used);
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            access(1'b0, 2, 1, k, '0, rd, used, stalled);
            check_word("proc_rdata", (k == 0) ? 32'hbeef_0200 : word_of(ref_line, k), rd);
        end
    endtask

    task automatic test_lru_replacement();
        word_t rd;
        logic  used;
        logic  stalled;
        access(1'b0, 3, 2, 0, '0, rd, used, stalled);
        access(1'b0, 4, 2, 0, '0, rd, used, stalled);
        // touch tag 3 so tag 4 becomes least recently used
        access(1'b0, 3, 2, 1, '0, rd, used, stalled);
        access(1'b0, 5, 2, 0, '0, rd, used, stalled);
        check_word("proc_rdata", word_of(model_line(5, 2), 0), rd);
        access(1'b0, 3, 2, 2, '0, rd, used, stalled);
        check_flag("memory request", 1'b0, used);
        check_word("proc_rdata", word_of(model_line(3, 2), 2), rd);
        access(1'b0, 4, 2, 3, '0, rd, used, stalled);
        check_flag("memory request", 1'b1, used);
        check_mem_addr("mem_addr", line_addr(4, 2), last_rd_addr);
        check_word("proc_rdata", word_of(model_line(4, 2), 3), rd);
    endtask

    task automatic test_dirty_eviction();
        word_t rd;
        logic  used;
        logic  stalled;
        line_t exp_line;
        int    wb_before;
        exp_line = model_line(6, 3);
        access(1'b0, 6, 3, 0, '0, rd, used, stalled);
        access(1'b1, 6, 3, 1, 32'h1111_6301, rd, used, stalled);
        access(1'b1, 6, 3, 3, 32'h3333_6303, rd, used, stalled);
        access(1'b0, 7, 3, 0, '0, rd, used, stalled);
        exp_line[1*WORD_W +: WORD_W] = 32'h1111_6301;
        exp_line[3*WORD_W +: WORD_W] = 32'h3333_6303;
        wb_before = wb_addr.size();
        access(1'b0, 8, 3, 2, '0, rd, used, stalled);
        if (wb_addr.size() != wb_before + 1) begin
            errors++;
            $display("dirty eviction gave %0d write-backs instead of one",
                     wb_addr.size() - wb_before);
        end else begin
            check_mem_addr("write-back mem_addr", line_addr(6, 3), wb_addr[$]);
            check_line("mem_wdata", exp_line, wb_line[$]);
        end
        check_mem_addr("fill mem_addr", line_addr(8, 3), last_rd_addr);
        check_word("proc_rdata", word_of(model_line(8, 3), 2), rd);
    endtask

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed       = 32'h110d82b2;
        errors     = 0;
        checks     = 0;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        wait_cnt   = 0;
        latency    = 1;
        for (int i = 0; i < MODEL_LINES; i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_model[i][w*WORD_W +: WORD_W] = $random(seed);
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        proc_reset = 1'b0;
        test_reset_and_first_read();
        test_read_hit();
        test_write_paths();
        test_lru_replacement();
        test_dirty_eviction();
        // failed protocol assertions count as errors too
        errors = errors + i_dut.i_assertions.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/cache_pkg.sv
hdl/line_ram.sv
hdl/set_status.sv
hdl/way_lookup.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/cache_assertions.sv
test/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f build.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 ; cat sim.log 2>/dev/null
test -f sim.log \
    && grep -q "NO ERRORS" sim.log \
    && ! grep -q "ERRORS FOUND" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
